/* Makefile */
# Verilator build, run, lint and clean for the radix-4 divider

VERILATOR ?= verilator
TOP       ?= tb_div
RTL_TOP   ?= div_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
div_pkg.sv
div_operand_prep.sv
div_multiple_gen.sv
div_radix4_step.sv
div_iter_ctrl.sv
div_result_fix.sv
div_top.sv
tb_div.sv

/* div_iter_ctrl.sv */
// step sequencer: accepts start, runs 32 radix-4 steps, holds remainder and quotient, flags finish
`timescale 1ns/1ps
`default_nettype none

module div_iter_ctrl (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       start_i,
	input  logic [div_pkg::DATA_W-1:0] dividend_abs_i,
	input  logic [1:0]                 quo_bits_i,
	input  logic [div_pkg::DATA_W-1:0] rem_next_i,
	output logic                       load_o,
	output logic                       busy_o,
	output logic                       finish_o,
	output logic [div_pkg::CNT_W-1:0]  step_idx_o,
	output logic [div_pkg::DATA_W-1:0] rem_o,
	output logic [1:0]                 dividend_pair_o,
	output logic [div_pkg::DATA_W-1:0] quo_raw_o
);
	import div_pkg::*;

	logic              busy_q;
	logic              finish_q;
	logic [CNT_W-1:0]  cnt_q;
	logic              step_en;
	logic              last_step;
	// partial remainder
	logic [DATA_W-1:0] rem_q;
	// quotient bits shift in at the bottom
	logic [DATA_W-1:0] quo_q;

	// ==============================
	// control
	// ==============================

	// a start while busy is dropped
	assign load_o = start_i & ~busy_q;

	// no step in the finish cycle
	assign step_en   = busy_q & ~finish_q;
	assign last_step = (cnt_q == CNT_W'(ITER_N - 1));

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			busy_q   <= 1'b0;
			finish_q <= 1'b0;
			cnt_q    <= '0;
		end else begin
			if (load_o) begin
				busy_q <= 1'b1;
				cnt_q  <= '0;
			end else if (finish_q) begin
				busy_q <= 1'b0;
			end else if (step_en && !last_step) begin
				cnt_q <= cnt_q + 1'b1;
			end
			// counter parks at the top, finish follows the last step
			finish_q <= step_en & last_step;
		end
	end

	// ==============================
	// datapath
	// ==============================

	always_ff @(posedge clk_i) begin
		if (load_o) begin
			rem_q <= '0;
		end else if (step_en) begin
			rem_q <= rem_next_i;
			quo_q <= (quo_q << 2) | {{(DATA_W-2){1'b0}}, quo_bits_i};
		end
	end

	// dividend walked from the top, bits 63-2k and 62-2k
	assign dividend_pair_o = dividend_abs_i[{~cnt_q, 1'b1} -: 2];

	assign busy_o     = busy_q;
	assign finish_o   = finish_q;
	assign step_idx_o = cnt_q;
	assign rem_o      = rem_q;
	assign quo_raw_o  = quo_q;

	// ==============================
	// checks
	// ==============================

	// a run is exactly ITER_N steps, finish in the cycle right after
	a_cnt_top: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		load_o |-> ##(ITER_N + 1) finish_o);

	a_finish_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		finish_o |=> !finish_o);

	// load only from idle, and the run starts at step 0
	a_load_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		load_o |-> !busy_o ##1 (busy_o && step_idx_o == '0));

endmodule

`default_nettype wire

/* div_multiple_gen.sv */
// divisor multiples 3d and the per-position force-zero flags, combinational from the held divisor
`timescale 1ns/1ps
`default_nettype none

module div_multiple_gen (
	input  logic [div_pkg::DATA_W-1:0] divisor_adj_i,
	input  logic                       divisor_sign_i,
	output logic [div_pkg::MUL3_W-1:0] divisor_x3_o,
	output logic [div_pkg::DATA_W-1:0] d_force_zero_o,
	output logic [div_pkg::DATA_W-1:0] d3_force_zero_o
);
	import div_pkg::*;

	logic [MUL3_W-1:0] d3;
	// divisor magnitude wider than the partial remainder
	logic [DATA_W-1:0] d_hi_flag;
	// negative power of two correction
	logic [DATA_W-1:0] d_lo_flag;
	logic [DATA_W-1:0] d3_hi_flag;
	logic [DATA_W-1:0] d3_lo_flag;

	// 3d = d + 2d, extended with the operand sign
	assign d3 = {divisor_sign_i, divisor_sign_i, divisor_adj_i}
		+ {divisor_sign_i, divisor_adj_i, 1'b0};
	assign divisor_x3_o = d3;

	// ==============================
	// d flags, all positions
	// ==============================

	// positive d: any one above j means d does not fit in j+1 bits
	// negative d: leading ones stop above j, bit 63 is known to be one
	// a negative power of two looks one position too wide, lo flag catches it
	for (genvar j = 0; j < DATA_W; j++) begin : g_d_flag
		localparam logic [DATA_W-1:0] LOW = {DATA_W{1'b1}} >> (DATA_W - 1 - j);

		assign d_hi_flag[j] = divisor_sign_i
			? ~&(divisor_adj_i[DATA_W-2:0] | LOW[DATA_W-2:0])
			: |(divisor_adj_i & ~LOW);
		assign d_lo_flag[j] = divisor_sign_i & ~|(divisor_adj_i & LOW);
		assign d_force_zero_o[j] = d_hi_flag[j] | d_lo_flag[j];
	end

	// ==============================
	// 3d flags, odd positions
	// ==============================

	for (genvar j = 0; j < DATA_W; j++) begin : g_d3_flag
		if (j % 2 == 1) begin : g_odd
			localparam logic [MUL3_W-1:0] LOW3 = {MUL3_W{1'b1}} >> (MUL3_W - 1 - j);

			// same rule as d, one extra sign bit to skip
			assign d3_hi_flag[j] = divisor_sign_i
				? ~&(d3[MUL3_W-2:0] | LOW3[MUL3_W-2:0])
				: |(d3 & ~LOW3);
			assign d3_lo_flag[j] = divisor_sign_i & ~|(d3 & LOW3);
		end else begin : g_even
			// 3d trial only exists on the second bit of a step
			assign d3_hi_flag[j] = 1'b0;
			assign d3_lo_flag[j] = 1'b0;
		end
		assign d3_force_zero_o[j] = d3_hi_flag[j] | d3_lo_flag[j];
	end

endmodule

`default_nettype wire

/* div_operand_prep.sv */
// operand front end: format decode, sign extension and dividend magnitude, captured on load
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       load_i,
	input  logic [div_pkg::FMT_W-1:0]  op_format_i,
	input  logic                       op_sign_i,
	input  logic [div_pkg::DATA_W-1:0] dividend_i,
	input  logic [div_pkg::DATA_W-1:0] divisor_i,
	output logic [div_pkg::DATA_W-1:0] dividend_abs_o,
	output logic [div_pkg::DATA_W-1:0] dividend_adj_o,
	output logic [div_pkg::DATA_W-1:0] divisor_adj_o,
	output logic                       divisor_sign_o,
	output logic                       quo_sign_o,
	output logic                       rem_sign_o,
	output logic                       div_zero_o
);
	import div_pkg::*;

	// bits that belong to the format
	logic [DATA_W-1:0] keep_mask;
	// single bit at the format's msb
	logic [DATA_W-1:0] top_mask;
	logic              dividend_sign;
	logic              divisor_sign;
	logic [DATA_W-1:0] dividend_adj;
	logic [DATA_W-1:0] divisor_adj;
	logic [DATA_W-1:0] dividend_abs;

	// format decode
	always_comb begin
		case (op_format_i)
			FMT_INT16: keep_mask = {{(DATA_W-16){1'b0}}, {16{1'b1}}};
			FMT_INT32: keep_mask = {{(DATA_W-32){1'b0}}, {32{1'b1}}};
			FMT_INT64: keep_mask = '1;
			// code 11 behaves as int64
			default:   keep_mask = '1;
		endcase
	end

	assign top_mask = keep_mask & ~(keep_mask >> 1);

	// sign only exists in signed mode
	assign dividend_sign = op_sign_i & |(dividend_i & top_mask);
	assign divisor_sign  = op_sign_i & |(divisor_i & top_mask);

	// sign or zero extension above the format, upper garbage dropped
	assign dividend_adj = (dividend_i & keep_mask) | ({DATA_W{dividend_sign}} & ~keep_mask);
	assign divisor_adj  = (divisor_i & keep_mask) | ({DATA_W{divisor_sign}} & ~keep_mask);

	// divider core works on |dividend|, divisor stays signed
	assign dividend_abs = dividend_sign ? -dividend_adj : dividend_adj;

	// flags
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			divisor_sign_o <= 1'b0;
			quo_sign_o     <= 1'b0;
			rem_sign_o     <= 1'b0;
			div_zero_o     <= 1'b0;
		end else if (load_i) begin
			divisor_sign_o <= divisor_sign;
			quo_sign_o     <= dividend_sign ^ divisor_sign;
			// remainder follows the dividend
			rem_sign_o     <= dividend_sign;
			div_zero_o     <= (divisor_adj == '0);
		end
	end

	// operand words
	always_ff @(posedge clk_i) begin
		if (load_i) begin
			dividend_abs_o <= dividend_abs;
			dividend_adj_o <= dividend_adj;
			divisor_adj_o  <= divisor_adj;
		end
	end

endmodule

`default_nettype wire

/* div_pkg.sv */
// shared widths, format codes and step counts for the radix-4 divider, imported by all RTL blocks
`default_nettype none

package div_pkg;

	// ==============================
	// datapath widths
	// ==============================

	// operands and results, int16/int32 are extended up to this width
	localparam int DATA_W = 64;

	// 3d needs two extra bits on top of d
	localparam int MUL3_W = DATA_W + 2;

	// ==============================
	// operand formats
	// ==============================

	localparam int FMT_W = 2;

	localparam logic [FMT_W-1:0] FMT_INT16 = 2'b00;
	localparam logic [FMT_W-1:0] FMT_INT32 = 2'b01;
	// code 11 decodes as int64 too
	localparam logic [FMT_W-1:0] FMT_INT64 = 2'b10;

	// ==============================
	// iteration
	// ==============================

	// two quotient bits per step
	localparam int ITER_N = DATA_W / 2;
	localparam int CNT_W  = $clog2(ITER_N);

endpackage

`default_nettype wire

/* div_radix4_step.sv */
// one radix-4 restoring step: two quotient bits, second bit speculated on both values of the first
`timescale 1ns/1ps
`default_nettype none

module div_radix4_step (
	input  logic [div_pkg::CNT_W-1:0]  step_idx_i,
	input  logic [div_pkg::DATA_W-1:0] rem_i,
	input  logic [1:0]                 dividend_pair_i,
	input  logic [div_pkg::DATA_W-1:0] divisor_adj_i,
	input  logic [div_pkg::MUL3_W-1:0] divisor_x3_i,
	input  logic                       divisor_sign_i,
	input  logic [div_pkg::DATA_W-1:0] d_force_zero_i,
	input  logic [div_pkg::DATA_W-1:0] d3_force_zero_i,
	output logic [1:0]                 quo_bits_o,
	output logic [div_pkg::DATA_W-1:0] rem_o
);
	import div_pkg::*;

	// stage positions 2k and 2k+1
	logic [CNT_W:0]    pos_even;
	logic [CNT_W:0]    pos_odd;
	// live width of the partial remainder per stage
	logic [DATA_W-1:0] mask_even;
	logic [DATA_W-1:0] mask_odd;
	// positive d is subtracted as ~d + 1, negative d is added
	logic              cin;
	logic [DATA_W-1:0] inv_d;
	logic [MUL3_W-1:0] inv_d3;
	logic [DATA_W-1:0] a_even;
	logic [DATA_W-1:0] a_odd;
	logic [DATA_W:0]   sum_even;
	logic [DATA_W-1:0] sum_even_lo;
	logic [DATA_W:0]   sum_q0;
	logic [MUL3_W-1:0] sum_q1;
	logic              q_even;
	logic              q_odd_0;
	logic              q_odd_1;
	logic [DATA_W-1:0] rem_q0;
	logic [DATA_W-1:0] rem_q1;

	assign pos_even = {step_idx_i, 1'b0};
	assign pos_odd  = {step_idx_i, 1'b1};

	// ~pos is 63-pos, so the masks hold pos+1 ones
	assign mask_even = {DATA_W{1'b1}} >> ~pos_even;
	assign mask_odd  = {DATA_W{1'b1}} >> ~pos_odd;

	assign cin    = ~divisor_sign_i;
	assign inv_d  = {DATA_W{cin}} ^ divisor_adj_i;
	assign inv_d3 = {MUL3_W{cin}} ^ divisor_x3_i;

	// shift in the next dividend bits
	assign a_even = (rem_i << 1) | {{(DATA_W-1){1'b0}}, dividend_pair_i[1]};
	assign a_odd  = (rem_i << 2) | {{(DATA_W-2){1'b0}}, dividend_pair_i};

	// ==============================
	// first bit, trial with d
	// ==============================

	assign sum_even = {1'b0, a_even} + {1'b0, inv_d & mask_even} + {{DATA_W{1'b0}}, cin};
	// operands are zero above the mask, so only the carry can land there
	assign q_even = |(sum_even & ~{1'b0, mask_even}) & ~d_force_zero_i[pos_even];
	assign sum_even_lo = sum_even[DATA_W-1:0] & mask_even;

	// ==============================
	// second bit, both guesses
	// ==============================

	// first bit 0: remainder unchanged, subtract d once
	assign sum_q0 = {1'b0, a_odd} + {1'b0, inv_d & mask_odd} + {{DATA_W{1'b0}}, cin};
	assign q_odd_0 = |(sum_q0 & ~{1'b0, mask_odd}) & ~d_force_zero_i[pos_odd];
	assign rem_q0  = q_odd_0 ? (sum_q0[DATA_W-1:0] & mask_odd) : a_odd;

	// first bit 1: 4r + bits - 2d - d
	assign sum_q1 = MUL3_W'(a_odd) + (inv_d3 & MUL3_W'(mask_odd)) + MUL3_W'(cin);
	assign q_odd_1 = |(sum_q1 & ~MUL3_W'(mask_odd)) & ~d3_force_zero_i[pos_odd];
	// restore to the first stage's difference, not to a_odd
	assign rem_q1 = q_odd_1 ? (sum_q1[DATA_W-1:0] & mask_odd)
		: (sum_even_lo << 1) | {{(DATA_W-1){1'b0}}, dividend_pair_i[0]};

	// late select on the first bit
	assign quo_bits_o = {q_even, q_even ? q_odd_1 : q_odd_0};
	assign rem_o      = q_even ? rem_q1 : rem_q0;

endmodule

`default_nettype wire

/* div_result_fix.sv */
// result stage: sign correction, divide-by-zero override, output register and done pulse
`timescale 1ns/1ps
`default_nettype none

module div_result_fix (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       finish_i,
	input  logic [div_pkg::DATA_W-1:0] quo_raw_i,
	input  logic [div_pkg::DATA_W-1:0] rem_raw_i,
	input  logic                       quo_sign_i,
	input  logic                       rem_sign_i,
	input  logic                       div_zero_i,
	input  logic [div_pkg::DATA_W-1:0] dividend_adj_i,
	output logic                       done_o,
	output logic [div_pkg::DATA_W-1:0] quotient_o,
	output logic [div_pkg::DATA_W-1:0] remainder_o,
	output logic                       div_zero_o
);
	import div_pkg::*;

	logic [DATA_W-1:0] quo_fix;
	logic [DATA_W-1:0] rem_fix;

	// magnitudes back to two's complement, x/0 gives all ones and x
	assign quo_fix = div_zero_i ? '1 : (quo_sign_i ? -quo_raw_i : quo_raw_i);
	assign rem_fix = div_zero_i ? dividend_adj_i : (rem_sign_i ? -rem_raw_i : rem_raw_i);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			done_o      <= 1'b0;
			quotient_o  <= '0;
			remainder_o <= '0;
			div_zero_o  <= 1'b0;
		end else begin
			done_o <= finish_i;
			// held until the next division completes
			if (finish_i) begin
				quotient_o  <= quo_fix;
				remainder_o <= rem_fix;
				div_zero_o  <= div_zero_i;
			end
		end
	end

	// one done per division
	a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |=> !done_o);

endmodule

`default_nettype wire

/* div_top.sv */
// multicycle radix-4 divider top, 16/32/64-bit signed or unsigned, start to done in 33 cycles
`timescale 1ns/1ps
`default_nettype none

module div_top (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       start_i,
	input  logic [div_pkg::FMT_W-1:0]  op_format_i,
	input  logic                       op_sign_i,
	input  logic [div_pkg::DATA_W-1:0] dividend_i,
	input  logic [div_pkg::DATA_W-1:0] divisor_i,
	output logic                       busy_o,
	output logic                       done_o,
	output logic [div_pkg::DATA_W-1:0] quotient_o,
	output logic [div_pkg::DATA_W-1:0] remainder_o,
	output logic                       div_zero_o
);
	import div_pkg::*;

	// operand stage
	logic              load;
	logic [DATA_W-1:0] dividend_abs;
	logic [DATA_W-1:0] dividend_adj;
	logic [DATA_W-1:0] divisor_adj;
	logic              divisor_sign;
	logic              quo_sign;
	logic              rem_sign;
	logic              div_zero;
	// multiples and flags
	logic [MUL3_W-1:0] divisor_x3;
	logic [DATA_W-1:0] d_force_zero;
	logic [DATA_W-1:0] d3_force_zero;
	// step loop
	logic [CNT_W-1:0]  step_idx;
	logic [DATA_W-1:0] rem_cur;
	logic [DATA_W-1:0] rem_next;
	logic [1:0]        dividend_pair;
	logic [1:0]        quo_bits;
	logic              finish;
	logic [DATA_W-1:0] quo_raw;

	div_operand_prep u_prep (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.load_i         (load),
		.op_format_i    (op_format_i),
		.op_sign_i      (op_sign_i),
		.dividend_i     (dividend_i),
		.divisor_i      (divisor_i),
		.dividend_abs_o (dividend_abs),
		.dividend_adj_o (dividend_adj),
		.divisor_adj_o  (divisor_adj),
		.divisor_sign_o (divisor_sign),
		.quo_sign_o     (quo_sign),
		.rem_sign_o     (rem_sign),
		.div_zero_o     (div_zero)
	);

	div_multiple_gen u_mult (
		.divisor_adj_i   (divisor_adj),
		.divisor_sign_i  (divisor_sign),
		.divisor_x3_o    (divisor_x3),
		.d_force_zero_o  (d_force_zero),
		.d3_force_zero_o (d3_force_zero)
	);

	div_radix4_step u_step (
		.step_idx_i      (step_idx),
		.rem_i           (rem_cur),
		.dividend_pair_i (dividend_pair),
		.divisor_adj_i   (divisor_adj),
		.divisor_x3_i    (divisor_x3),
		.divisor_sign_i  (divisor_sign),
		.d_force_zero_i  (d_force_zero),
		.d3_force_zero_i (d3_force_zero),
		.quo_bits_o      (quo_bits),
		.rem_o           (rem_next)
	);

	div_iter_ctrl u_ctrl (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.start_i         (start_i),
		.dividend_abs_i  (dividend_abs),
		.quo_bits_i      (quo_bits),
		.rem_next_i      (rem_next),
		.load_o          (load),
		.busy_o          (busy_o),
		.finish_o        (finish),
		.step_idx_o      (step_idx),
		.rem_o           (rem_cur),
		.dividend_pair_o (dividend_pair),
		.quo_raw_o       (quo_raw)
	);

	div_result_fix u_fix (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.finish_i       (finish),
		.quo_raw_i      (quo_raw),
		.rem_raw_i      (rem_cur),
		.quo_sign_i     (quo_sign),
		.rem_sign_i     (rem_sign),
		.div_zero_i     (div_zero),
		.dividend_adj_i (dividend_adj),
		.done_o         (done_o),
		.quotient_o     (quotient_o),
		.remainder_o    (remainder_o),
		.div_zero_o     (div_zero_o)
	);

endmodule

`default_nettype wire

/* tb_div.sv */
// testbench for div_top, runs a stimulus table and lfsr operands against a truncating division model
`timescale 1ns/1ps
`default_nettype none

module tb_div;
	import div_pkg::*;

	localparam int          TIMEOUT_CYC = 100;
	// accepting edge to done edge
	localparam int          DONE_EDGE   = 33;
	localparam int          RAND_N      = 40;
	localparam logic [31:0] SEED        = 32'd9763;

	logic              clk;
	logic              rst_n;
	logic              start;
	logic [FMT_W-1:0]  op_format;
	logic              op_sign;
	logic [DATA_W-1:0] dividend;
	logic [DATA_W-1:0] divisor;
	logic              busy_o;
	logic              done_o;
	logic [DATA_W-1:0] quotient_o;
	logic [DATA_W-1:0] remainder_o;
	logic              div_zero_o;

	// stimulus table columns
	string             tbl_name[$];
	logic [FMT_W-1:0]  tbl_fmt[$];
	logic              tbl_sgn[$];
	logic [DATA_W-1:0] tbl_a[$];
	logic [DATA_W-1:0] tbl_b[$];

	int                word_errors;
	int                bit_errors;
	int                other_errors;
	bit                timed_out;
	logic [31:0]       lfsr_state;

	div_top dut_i (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.start_i     (start),
		.op_format_i (op_format),
		.op_sign_i   (op_sign),
		.dividend_i  (dividend),
		.divisor_i   (divisor),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.quotient_o  (quotient_o),
		.remainder_o (remainder_o),
		.div_zero_o  (div_zero_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ==============================
	// compare tasks
	// ==============================

	task automatic check_word(input string name, input string what,
		input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			word_errors++;
			$display("Error: %s %s: expected %h, actual %h", name, what, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input string what, input logic exp, input logic act);
		if (act !== exp) begin
			bit_errors++;
			$display("Error: %s %s: expected %b, actual %b", name, what, exp, act);
		end
	endtask

	// ==============================
	// reference model
	// ==============================

	// operand as the format sees it, upper garbage replaced by the extension
	function automatic logic [DATA_W-1:0] extend_operand(input logic [DATA_W-1:0] v,
		input logic [FMT_W-1:0] fmt, input logic sgn);
		case (fmt)
			FMT_INT16: return {{(DATA_W-16){sgn & v[15]}}, v[15:0]};
			FMT_INT32: return {{(DATA_W-32){sgn & v[31]}}, v[31:0]};
			default:   return v;
		endcase
	endfunction

	task automatic model_division(input logic [FMT_W-1:0] fmt, input logic sgn,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		output logic [DATA_W-1:0] q, output logic [DATA_W-1:0] r, output logic z);
		logic [DATA_W-1:0] a_ext;
		logic [DATA_W-1:0] b_ext;
		logic [DATA_W-1:0] a_mag;
		logic [DATA_W-1:0] b_mag;
		logic              a_neg;
		logic              b_neg;
		a_ext = extend_operand(a, fmt, sgn);
		b_ext = extend_operand(b, fmt, sgn);
		a_neg = sgn & a_ext[DATA_W-1];
		b_neg = sgn & b_ext[DATA_W-1];
		z     = (b_ext == '0);
		if (z) begin
			q = '1;
			r = a_ext;
		end else begin
			// magnitudes keep min / -1 out of signed overflow
			a_mag = a_neg ? -a_ext : a_ext;
			b_mag = b_neg ? -b_ext : b_ext;
			q = (a_neg ^ b_neg) ? -(a_mag / b_mag) : a_mag / b_mag;
			// truncating, remainder follows the dividend
			r = a_neg ? -(a_mag % b_mag) : a_mag % b_mag;
		end
	endtask

	// ==============================
	// stimulus helpers
	// ==============================

	// 32-bit galois, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [DATA_W-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[DATA_W-2:0], lfsr_state[0]};
		end
	endtask

	task automatic add_entry(input string name, input logic [FMT_W-1:0] fmt, input logic sgn,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		tbl_name.push_back(name);
		tbl_fmt.push_back(fmt);
		tbl_sgn.push_back(sgn);
		tbl_a.push_back(a);
		tbl_b.push_back(b);
	endtask

	task automatic build_table();
		// unsigned per format, incl dividend below divisor
		add_entry("u64_basic", FMT_INT64, 1'b0, 64'd1000000007, 64'd97);
		add_entry("u64_wide", FMT_INT64, 1'b0, 64'hFFFFFFFFFFFFFFFF, 64'h100000003);
		add_entry("u64_small", FMT_INT64, 1'b0, 64'd5, 64'd9);
		add_entry("u32_basic", FMT_INT32, 1'b0, 64'hDEADBEEF, 64'h1234);
		add_entry("u32_small", FMT_INT32, 1'b0, 64'd3, 64'hFFFFFFFF);
		add_entry("u16_basic", FMT_INT16, 1'b0, 64'hFFFF, 64'd7);
		add_entry("u16_small", FMT_INT16, 1'b0, 64'd2, 64'h8000);
		// signed, sign pairs and negative powers of two
		add_entry("s64_pp", FMT_INT64, 1'b1, 64'd100, 64'd7);
		add_entry("s64_np", FMT_INT64, 1'b1, -64'd100, 64'd7);
		add_entry("s64_pn", FMT_INT64, 1'b1, 64'd100, -64'd7);
		add_entry("s64_nn", FMT_INT64, 1'b1, -64'd100, -64'd7);
		add_entry("s64_npow2", FMT_INT64, 1'b1, 64'd12345, -64'd64);
		add_entry("s64_min_m1", FMT_INT64, 1'b1, 64'h8000000000000000, -64'd1);
		add_entry("s64_min_div", FMT_INT64, 1'b1, -64'd12345, 64'h8000000000000000);
		add_entry("s32_pp", FMT_INT32, 1'b1, 64'h7FFFFFFF, 64'd13);
		add_entry("s32_np", FMT_INT32, 1'b1, 64'h80000001, 64'd13);
		add_entry("s32_pn", FMT_INT32, 1'b1, 64'd1234567, 64'hFFFFFFFD);
		add_entry("s32_nn", FMT_INT32, 1'b1, 64'hFFED2979, 64'hFFFFFC18);
		add_entry("s32_npow2", FMT_INT32, 1'b1, 64'd999, 64'hFFFFFFF0);
		add_entry("s16_pp", FMT_INT16, 1'b1, 64'd30000, 64'd7);
		add_entry("s16_np", FMT_INT16, 1'b1, 64'h8000, 64'd3);
		add_entry("s16_pn", FMT_INT16, 1'b1, 64'd1000, 64'hFFF9);
		add_entry("s16_nn", FMT_INT16, 1'b1, 64'hFF00, 64'hFFF9);
		add_entry("s16_npow2", FMT_INT16, 1'b1, 64'd1000, 64'hFFFE);
		// divide by zero, upper divisor bits outside the format
		add_entry("z64", FMT_INT64, 1'b0, 64'd12345, 64'd0);
		add_entry("z32_upper", FMT_INT32, 1'b1, 64'h1111222280000000, 64'hABCD000000000000);
		add_entry("z16_upper", FMT_INT16, 1'b0, 64'h4321, 64'h10000);
		// garbage above the format
		add_entry("g16", FMT_INT16, 1'b1, 64'h123456789ABCFFF6, 64'hFFFF000000000003);
		add_entry("g32", FMT_INT32, 1'b0, 64'hFFFFFFFF00000064, 64'h555555550000000A);
		add_entry("fmt11", 2'b11, 1'b1, -64'd1000, 64'd33);
	endtask

	// ==============================
	// one division
	// ==============================

	// entered and left 1 ns after a rising edge
	task automatic run_division(input string name, input logic [FMT_W-1:0] fmt, input logic sgn,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input bit restart);
		logic [DATA_W-1:0] exp_q;
		logic [DATA_W-1:0] exp_r;
		logic              exp_z;
		int                n;
		bit                seen_done;
		model_division(fmt, sgn, a, b, exp_q, exp_r, exp_z);
		op_format = fmt;
		op_sign   = sgn;
		dividend  = a;
		divisor   = b;
		start     = 1'b1;
		// accepting edge
		@(posedge clk);
		#1;
		start     = 1'b0;
		n         = 0;
		seen_done = 1'b0;
		while (!seen_done && n < TIMEOUT_CYC) begin
			@(posedge clk);
			#1;
			n++;
			seen_done = (done_o === 1'b1);
			if (!seen_done && n < DONE_EDGE)
				check_bit(name, "busy", 1'b1, busy_o);
			// second start mid-run with other operands, must be dropped
			if (restart && n == 10) begin
				start     = 1'b1;
				op_format = FMT_INT64;
				op_sign   = ~sgn;
				dividend  = ~a;
				divisor   = 64'd3;
			end
			if (restart && n == 11)
				start = 1'b0;
		end
		if (!seen_done) begin
			other_errors++;
			timed_out = 1'b1;
			$display("Timeout: %s saw no done within %0d cycles", name, TIMEOUT_CYC);
		end else begin
			if (n != DONE_EDGE) begin
				other_errors++;
				$display("Error: %s done edge: expected %0d, actual %0d", name, DONE_EDGE, n);
			end
			check_bit(name, "busy at done", 1'b0, busy_o);
			check_word(name, "quotient", exp_q, quotient_o);
			check_word(name, "remainder", exp_r, remainder_o);
			check_bit(name, "div_zero", exp_z, div_zero_o);
			@(posedge clk);
			#1;
			// single cycle done, results held
			check_bit(name, "done width", 1'b0, done_o);
			check_word(name, "quotient hold", exp_q, quotient_o);
		end
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin
		logic [DATA_W-1:0] r_fmt;
		logic [DATA_W-1:0] r_sgn;
		logic [DATA_W-1:0] r_a;
		logic [DATA_W-1:0] r_b;
		logic [DATA_W-1:0] r_shift;
		int                total;
		word_errors  = 0;
		bit_errors   = 0;
		other_errors = 0;
		timed_out    = 1'b0;
		lfsr_state   = SEED;
		rst_n        = 1'b0;
		start        = 1'b0;
		op_format    = FMT_INT64;
		op_sign      = 1'b0;
		dividend     = '0;
		divisor      = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// idle outputs straight out of reset
		check_bit("reset", "busy", 1'b0, busy_o);
		check_bit("reset", "done", 1'b0, done_o);
		check_word("reset", "quotient", '0, quotient_o);
		check_word("reset", "remainder", '0, remainder_o);
		check_bit("reset", "div_zero", 1'b0, div_zero_o);
		build_table();
		for (int i = 0; i < tbl_name.size() && !timed_out; i++)
			run_division(tbl_name[i], tbl_fmt[i], tbl_sgn[i], tbl_a[i], tbl_b[i], 1'b0);
		if (!timed_out)
			run_division("busy_restart", FMT_INT32, 1'b1, 64'hFFFFFFFF87654321, 64'h25, 1'b1);
		for (int i = 0; i < RAND_N && !timed_out; i++) begin
			take_bits(2, r_fmt);
			take_bits(1, r_sgn);
			take_bits(DATA_W, r_a);
			take_bits(DATA_W, r_b);
			// spread divisor sizes
			take_bits(6, r_shift);
			r_b = r_b >> r_shift[5:0];
			run_division($sformatf("rand_%0d", i), r_fmt[1:0], r_sgn[0], r_a, r_b, 1'b0);
		end
		total = word_errors + bit_errors + other_errors;
		$display("errors: %0d word, %0d flag, %0d other", word_errors, bit_errors, other_errors);
		if (total == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
